//--- filelist.f
rtl/fetch_pkg.sv
rtl/branch_predecode.sv
rtl/icache.sv
rtl/fetch_unit.sv
dv/inst_mem_model.sv
dv/fetch_props.sv
dv/tb_fetch.sv

//--- dv/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
	import fetch_pkg::*;

	// ******************************
	// constants and signals
	// ******************************

	localparam addr_t BASE_PC     = 64'h8000_0000;
	localparam int    NUM_LINES   = 16;
	localparam int    MEM_LATENCY = 3;
	localparam int    MEM_LINES   = 64;
	localparam int    PROG_WORDS  = MEM_LINES * LINE_WORDS;
	// idle cycles allowed between two accepted words
	localparam int    WAIT_LIMIT  = 100;

	logic  clk;
	logic  rst;
	logic  id_ready;
	logic  redirect;
	addr_t redirect_pc;
	logic  inst_valid;
	inst_t inst;
	addr_t inst_pc;
	logic  mem_req;
	addr_t mem_addr;
	logic  mem_ack;
	line_t mem_rdata;
	int    refills;

	// program image, 1 KiB window starting at BASE_PC
	inst_t prog [PROG_WORDS];
	int    seed = 23;

	fetch_unit #(
		.RESET_PC  (BASE_PC),
		.NUM_LINES (NUM_LINES)
	) DUT (
		.clk         (clk),
		.rst         (rst),
		.id_ready    (id_ready),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata)
	);

	inst_mem_model #(
		.LATENCY   (MEM_LATENCY),
		.MEM_LINES (MEM_LINES)
	) u_mem (
		.clk       (clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.refills   (refills)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// a bound assertion failure ends the run at the next edge
	always @(posedge clk) begin
		if (DUT.u_icache.u_props.fail_count != 0) begin
			$display("a bus assertion on the icache failed");
			$display("Test FAILED");
			$fatal(1, "assertion failure");
		end
	end

	// ******************************
	// program and reference model
	// ******************************

	// addi type word, never a jump or a branch
	function automatic inst_t filler(input addr_t a);
		return {a[63:39] ^ a[56:32] ^ a[31:7] ^ a[24:0], 7'b0010011};
	endfunction

	function automatic inst_t word_at(input addr_t a);
		return prog[a[2 +: $clog2(PROG_WORDS)]];
	endfunction

	// static prediction rule, jal and backward branches taken
	function automatic bit predict_taken(input inst_t w);
		logic is_branch;
		// funct3 010 and 011 are no branches
		is_branch = (w[6:0] == OPC_BRANCH) && (w[14:13] != 2'b01);
		return (w[6:0] == OPC_JAL) || (is_branch && w[31]);
	endfunction

	// jump offset only when taken, else the next word
	function automatic addr_t predict_next(input addr_t pc, input inst_t w);
		logic signed [63:0] off_j;
		logic signed [63:0] off_b;
		off_j = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
		off_b = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
		if (!predict_taken(w))
			return pc + 64'd4;
		if (w[6:0] == OPC_JAL)
			return pc + off_j;
		return pc + off_b;
	endfunction

	task automatic clear_program();
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = filler(BASE_PC + addr_t'(4 * i));
		end
	endtask

	// w1 jal +32, w9 beq +8, w10 bad funct3 -16, w11 bne -40 back to w1
	task automatic branch_program();
		clear_program();
		prog[1]  = 32'h020000EF;
		prog[9]  = 32'h00208463;
		prog[10] = 32'hFE20A8E3;
		prog[11] = 32'hFC209CE3;
	endtask

	// ******************************
	// drive and check helpers
	// ******************************

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		next_cycle();
		rst      = 1'b1;
		id_ready = 1'b0;
		redirect = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	// copy the image into the line memory, then reset
	task automatic restart();
		for (int l = 0; l < MEM_LINES; l++) begin
			u_mem.lines[l] = {prog[4*l+3], prog[4*l+2], prog[4*l+1], prog[4*l]};
		end
		apply_reset();
	endtask

	task automatic expect_value(input string test, input string what,
			input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic require(input bit cond, input string test, input string msg);
		assert (cond) else begin
			$display("%s: %s", test, msg);
			$display("Test FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// one cycle redirect, decode not ready meanwhile
	task automatic pulse_redirect(input addr_t target);
		next_cycle();
		redirect    = 1'b1;
		redirect_pc = target;
		id_ready    = 1'b0;
		next_cycle();
		redirect = 1'b0;
	endtask

	// follow the reference model over count accepted words
	task automatic expect_stream(input string test, input addr_t start,
			input int count, input bit stall);
		addr_t exp_pc;
		inst_t exp_inst;
		addr_t held_pc;
		inst_t held_inst;
		logic  held;
		logic  ready;
		int    got;
		int    idle;
		exp_pc = start;
		held   = 1'b0;
		got    = 0;
		idle   = 0;
		while (got < count) begin
			next_cycle();
			// a stalled word stays put
			if (held) begin
				expect_value(test, "held inst_valid", 64'd1, inst_valid);
				expect_value(test, "held inst_pc", held_pc, inst_pc);
				expect_value(test, "held inst", held_inst, inst);
			end
			ready    = stall ? (($random(seed) & 3) != 0) : 1'b1;
			id_ready = ready;
			if (inst_valid && ready) begin
				exp_inst = word_at(exp_pc);
				expect_value(test, "inst_pc", exp_pc, inst_pc);
				expect_value(test, "inst", exp_inst, inst);
				// predecoder direction for the word being taken
				expect_value(test, "pred_taken", predict_taken(exp_inst), DUT.pred_taken);
				exp_pc = predict_next(exp_pc, exp_inst);
				got++;
				idle = 0;
			end else begin
				idle++;
				require(idle < WAIT_LIMIT, test, "timed out waiting for an instruction");
			end
			held      = inst_valid && !ready;
			held_pc   = inst_pc;
			held_inst = inst;
		end
	endtask

	// ******************************
	// directed tests
	// ******************************

	task automatic reset_state();
		clear_program();
		restart();
		expect_value("reset_state", "mem_req", 64'd0, mem_req);
		expect_value("reset_state", "inst_valid", 64'd0, inst_valid);
		expect_stream("reset_state", BASE_PC, 1, 1'b0);
	endtask

	task automatic sequential_fetch();
		clear_program();
		restart();
		expect_stream("sequential", BASE_PC, 20, 1'b0);
		// five lines touched, one refill each
		expect_value("sequential", "refills", 64'd5, refills);
	endtask

	task automatic static_prediction();
		branch_program();
		restart();
		expect_stream("prediction", BASE_PC, 14, 1'b0);
	endtask

	task automatic back_pressure();
		branch_program();
		restart();
		expect_stream("back_pressure", BASE_PC, 40, 1'b1);
	endtask

	task automatic redirect_fetch();
		int waited;
		clear_program();
		restart();
		waited = 0;
		// catch the first refill, redirect lands inside it
		while (!mem_req) begin
			next_cycle();
			waited++;
			require(waited < WAIT_LIMIT, "redirect", "no refill request after reset");
		end
		// first refill asks for the line of the reset pc
		expect_value("redirect", "mem_addr", BASE_PC, mem_addr);
		pulse_redirect(BASE_PC + 64'h140);
		expect_stream("redirect", BASE_PC + 64'h140, 6, 1'b0);
		// plain redirect while streaming
		pulse_redirect(BASE_PC + 64'h24);
		expect_stream("redirect", BASE_PC + 64'h24, 6, 1'b0);
	endtask

	// w11 blt -44 back to w0, loop over three lines
	task automatic cache_reuse();
		clear_program();
		prog[11] = 32'hFC20CAE3;
		restart();
		expect_stream("cache_reuse", BASE_PC, 48, 1'b0);
		expect_value("cache_reuse", "refills", 64'd3, refills);
	endtask

	initial begin
		rst         = 1'b1;
		id_ready    = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		reset_state();
		sequential_fetch();
		static_prediction();
		back_pressure();
		redirect_fetch();
		cache_reuse();
		if (DUT.u_icache.u_props.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("%0d bus assertions failed", DUT.u_icache.u_props.fail_count);
			$display("Test FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

//--- dv/fetch_props.sv
`timescale 1ns/1ps

module fetch_props (
	input logic             clk,
	input logic             rst,
	input logic             hit,
	input fetch_pkg::addr_t lookup_addr,
	input logic             mem_req,
	input fetch_pkg::addr_t mem_addr,
	input logic             mem_ack
);
	import fetch_pkg::*;

	// assertion failures seen so far
	int fail_count = 0;

	// request address frozen until the line comes back
	a_addr_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> $stable(mem_addr))
		else begin
			$error("mem_addr changed while a request was pending");
			fail_count++;
		end

	// the returned line serves its own address right after the fill
	a_fill_hits: assert property (@(posedge clk) disable iff (rst)
		$past(mem_req && mem_ack) &&
		(lookup_addr[63:LINE_OFFSET_BITS] == $past(mem_addr[63:LINE_OFFSET_BITS]))
		|-> hit)
		else begin
			$error("lookup missed on the line that was just filled");
			fail_count++;
		end

	// request only drops after its ack
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req)
		else begin
			$error("mem_req dropped before mem_ack");
			fail_count++;
		end

endmodule

bind icache fetch_props u_props (
	.clk         (clk),
	.rst         (rst),
	.hit         (hit),
	.lookup_addr (lookup_addr),
	.mem_req     (mem_req),
	.mem_addr    (mem_addr),
	.mem_ack     (mem_ack)
);

//--- dv/inst_mem_model.sv
`timescale 1ns/1ps

module inst_mem_model #(
	parameter int LATENCY   = 3,
	parameter int MEM_LINES = 64
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             mem_req,
	input  fetch_pkg::addr_t mem_addr,
	output logic             mem_ack,
	output fetch_pkg::line_t mem_rdata,
	// completed refills since reset
	output int               refills
);
	import fetch_pkg::*;

	localparam int INDEX_BITS = $clog2(MEM_LINES);

	// line storage, filled by the testbench
	line_t lines [MEM_LINES];

	// cycles spent on the current request
	int wait_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_ack   <= 1'b0;
			mem_rdata <= '0;
			wait_cnt  <= 0;
			refills   <= 0;
		end else begin
			// ack is a one cycle pulse
			mem_ack <= 1'b0;
			// no counting in the ack cycle itself
			if (mem_req && !mem_ack) begin
				if (wait_cnt == LATENCY - 1) begin
					mem_ack   <= 1'b1;
					mem_rdata <= lines[mem_addr[LINE_OFFSET_BITS +: INDEX_BITS]];
					wait_cnt  <= 0;
					refills   <= refills + 1;
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter fetch_pkg::addr_t RESET_PC  = 64'h8000_0000,
	parameter int               NUM_LINES = 16
) (
	input  logic             clk,
	input  logic             rst,

	// decode side
	input  logic             id_ready,
	output logic             inst_valid,
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t inst_pc,

	// execute side, one cycle pulse
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,

	// line refill port
	output logic             mem_req,
	output fetch_pkg::addr_t mem_addr,
	input  logic             mem_ack,
	input  fetch_pkg::line_t mem_rdata
);
	import fetch_pkg::*;

	// ******************************
	// internal signals
	// ******************************

	// current and next program counter
	addr_t pc_q;
	addr_t pc_d;

	// cache lookup result for pc_q
	logic  hit;
	inst_t hit_inst;

	// predecoder result for the word at pc_q
	addr_t pred_next_pc;
	// direction of the current prediction, for observation
	logic  pred_taken;

	// word handed to decode this cycle
	logic  advance;

	// ******************************
	// next pc selection
	// ******************************

	// consumed only when valid and decode takes it
	assign advance = hit && id_ready;

	// redirect wins over everything
	// then hold on miss or stall, else follow the prediction
	always_comb begin
		if (redirect) begin
			pc_d = redirect_pc;
		end else if (advance) begin
			pc_d = pred_next_pc;
		end else begin
			pc_d = pc_q;
		end
	end

	// pc register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_d;
		end
	end

	// ******************************
	// instruction cache
	// ******************************

	// looked up with the current pc, zero latency on a hit
	icache #(
		.NUM_LINES (NUM_LINES)
	) u_icache (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (pc_q),
		.hit         (hit),
		.hit_inst    (hit_inst),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata)
	);

	// ******************************
	// predecode
	// ******************************

	// sees the word straight from the hit path
	branch_predecode u_predecode (
		.pc           (pc_q),
		.inst         (hit_inst),
		.pred_next_pc (pred_next_pc),
		.pred_taken   (pred_taken)
	);

	// ******************************
	// decode outputs
	// ******************************

	// valid is the hit itself, low through any pending refill
	assign inst_valid = hit;
	assign inst       = hit_inst;
	// pc always shown, even when not valid
	assign inst_pc    = pc_q;

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int NUM_LINES = 16
) (
	input  logic             clk,
	input  logic             rst,
	// lookup side, combinational
	input  fetch_pkg::addr_t lookup_addr,
	output logic             hit,
	output fetch_pkg::inst_t hit_inst,
	// refill side
	output logic             mem_req,
	output fetch_pkg::addr_t mem_addr,
	input  logic             mem_ack,
	input  fetch_pkg::line_t mem_rdata
);
	import fetch_pkg::*;

	// ******************************
	// address split
	// ******************************

	localparam int ADDR_BITS  = $bits(addr_t);
	localparam int INST_BITS  = $bits(inst_t);
	localparam int INDEX_BITS = $clog2(NUM_LINES);
	localparam int WORD_BITS  = $clog2(LINE_WORDS);
	// whatever is left above index and offset
	localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - LINE_OFFSET_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   tag_t;
	typedef logic [WORD_BITS-1:0]  word_sel_t;

	// refill machine
	typedef enum logic {
		ST_IDLE,
		ST_REFILL
	} state_e;

	state_e state_q;
	state_e state_d;

	// ******************************
	// storage
	// ******************************

	// one valid bit per line, cleared on reset
	logic [NUM_LINES-1:0] valid_q;
	tag_t                 tag_q  [NUM_LINES];
	line_t                data_q [NUM_LINES];

	// line-aligned address of the pending miss
	addr_t miss_addr_q;

	// lookup decode
	index_t    lookup_index;
	tag_t      lookup_tag;
	word_sel_t lookup_word;
	line_t     lookup_line;
	inst_t     line_words [LINE_WORDS];
	logic      tag_match;

	// refill decode
	index_t fill_index;
	tag_t   fill_tag;
	logic   start_refill;
	logic   fill_done;

	assign lookup_index = lookup_addr[LINE_OFFSET_BITS +: INDEX_BITS];
	assign lookup_tag   = lookup_addr[ADDR_BITS-1 -: TAG_BITS];
	// bits 3:2 pick the word
	assign lookup_word  = lookup_addr[LINE_OFFSET_BITS-WORD_BITS +: WORD_BITS];

	assign fill_index = miss_addr_q[LINE_OFFSET_BITS +: INDEX_BITS];
	assign fill_tag   = miss_addr_q[ADDR_BITS-1 -: TAG_BITS];

	// ******************************
	// hit path
	// ******************************

	assign lookup_line = data_q[lookup_index];
	assign tag_match   = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

	// no hits while a refill is outstanding, even for another line
	assign hit = tag_match && (state_q == ST_IDLE);

	// cut the line into words, word 0 low
	always_comb begin
		for (int w = 0; w < LINE_WORDS; w++) begin
			line_words[w] = lookup_line[w*INST_BITS +: INST_BITS];
		end
	end

	assign hit_inst = line_words[lookup_word];

	// ******************************
	// refill FSM
	// ******************************

	// a miss seen in idle starts the refill on the next edge
	assign start_refill = (state_q == ST_IDLE) && !tag_match;

	// ack only counts while the request is up
	assign fill_done = (state_q == ST_REFILL) && mem_ack;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (start_refill) begin
					state_d = ST_REFILL;
				end
			end
			ST_REFILL: begin
				// always finish the line, a redirect does not cancel it
				if (mem_ack) begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// capture the missing line address, held for the whole refill
	always_ff @(posedge clk) begin
		if (start_refill) begin
			miss_addr_q <= {lookup_addr[ADDR_BITS-1:LINE_OFFSET_BITS],
				{LINE_OFFSET_BITS{1'b0}}};
		end
	end

	// valid bits
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (fill_done) begin
			valid_q[fill_index] <= 1'b1;
		end
	end

	// tag and data written together with the returned line
	always_ff @(posedge clk) begin
		if (fill_done) begin
			tag_q[fill_index]  <= fill_tag;
			data_q[fill_index] <= mem_rdata;
		end
	end

	// ******************************
	// memory port
	// ******************************

	// request is a level for the whole refill state
	assign mem_req  = (state_q == ST_REFILL);
	assign mem_addr = miss_addr_q;

endmodule

//--- rtl/branch_predecode.sv
`timescale 1ns/1ps

module branch_predecode (
	input  fetch_pkg::addr_t pc,
	input  fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t pred_next_pc,
	output logic             pred_taken
);
	import fetch_pkg::*;

	// ******************************
	// field extraction
	// ******************************

	logic [6:0] opcode;
	logic [2:0] funct3;
	// sign bit shared by both immediates
	logic       sign;

	pred_kind_e kind;

	// sign-extended immediates
	addr_t imm_b;
	addr_t imm_j;

	// candidate targets
	addr_t seq_pc;
	addr_t jal_target;
	addr_t br_target;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign sign   = inst[31];

	// ******************************
	// classify
	// ******************************

	// jal by opcode alone, branch needs a legal funct3
	always_comb begin
		kind = PRED_NONE;
		if (opcode == OPC_JAL) begin
			kind = PRED_JAL;
		end else if (opcode == OPC_BRANCH) begin
			case (funct3)
				BR_F3_BEQ,
				BR_F3_BNE,
				BR_F3_BLT,
				BR_F3_BGE,
				BR_F3_BLTU,
				BR_F3_BGEU: kind = PRED_BRANCH;
				// 010 and 011 are not branches
				default:    kind = PRED_NONE;
			endcase
		end
	end

	// ******************************
	// immediates
	// ******************************

	// B type, 13 bit offset, bit 0 always zero
	assign imm_b = {{51{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};

	// J type, 21 bit offset, bit 0 always zero
	assign imm_j = {{43{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};

	// ******************************
	// static prediction
	// ******************************

	assign seq_pc     = pc + 64'd4;
	assign jal_target = pc + imm_j;
	assign br_target  = pc + imm_b;

	// jal always taken
	// branch taken only when the offset points backwards
	always_comb begin
		case (kind)
			PRED_JAL: begin
				pred_taken   = 1'b1;
				pred_next_pc = jal_target;
			end
			PRED_BRANCH: begin
				pred_taken   = sign;
				pred_next_pc = sign ? br_target : seq_pc;
			end
			default: begin
				pred_taken   = 1'b0;
				pred_next_pc = seq_pc;
			end
		endcase
	end

endmodule

//--- rtl/fetch_pkg.sv
package fetch_pkg;

	// ******************************
	// widths with a meaning
	// ******************************

	// byte address or program counter
	typedef logic [63:0] addr_t;

	// one instruction word
	typedef logic [31:0] inst_t;

	// one cache line, word 0 sits in the low bits
	typedef logic [127:0] line_t;

	// ******************************
	// line geometry
	// ******************************

	// instructions per line
	localparam int LINE_WORDS = 4;

	// byte offset bits inside a line
	localparam int LINE_OFFSET_BITS = 4;

	// ******************************
	// instruction fields
	// ******************************

	// major opcodes the predecoder cares about
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// valid funct3 codes under OPC_BRANCH
	localparam logic [2:0] BR_F3_BEQ  = 3'b000;
	localparam logic [2:0] BR_F3_BNE  = 3'b001;
	localparam logic [2:0] BR_F3_BLT  = 3'b100;
	localparam logic [2:0] BR_F3_BGE  = 3'b101;
	localparam logic [2:0] BR_F3_BLTU = 3'b110;
	localparam logic [2:0] BR_F3_BGEU = 3'b111;

	// predecode class of a fetched word
	typedef enum logic [1:0] {
		PRED_NONE,
		PRED_JAL,
		PRED_BRANCH
	} pred_kind_e;

endpackage
